// File: source/icache_pkg.sv
// Address views, widths, FSM states and array write requests shared by all I-cache RTL files
package icache_pkg;

   localparam int IC_AW         = 32;                       // Physical address bits
   localparam int IC_P_LINE     = 5;                        // 32-byte lines
   localparam int IC_P_SETS     = 6;                        // 64 sets
   localparam int IC_P_WIN      = 3;                        // 8-byte fetch window
   localparam int IC_TAG_W      = IC_AW - IC_P_SETS - IC_P_LINE;
   localparam int IC_WIN_W      = 8 << IC_P_WIN;
   localparam int AXI_DW        = 64;
   localparam int IC_P_BEATS    = IC_P_LINE - IC_P_WIN;     // One R beat per window
   localparam int IC_BEATS      = 1 << IC_P_BEATS;
   localparam int IC_SETS       = 1 << IC_P_SETS;
   localparam int IC_WAY_MASK_W = 4;                        // Up to four ways

   // Tag compare view of an address
   typedef struct packed {
      logic [IC_TAG_W-1:0]  tag;
      logic [IC_P_SETS-1:0] set;
      logic [IC_P_LINE-1:0] offset;
   } icache_lookup_t;

   // Line and beat view, used for payload indexing and the burst address
   typedef struct packed {
      logic [IC_AW-IC_P_LINE-1:0] line;
      logic [IC_P_BEATS-1:0]      beat;
      logic [IC_P_WIN-1:0]        byte_idx;
   } icache_refill_t;

   typedef union packed {
      icache_lookup_t lookup;
      icache_refill_t refill;
   } icache_addr_u;

   typedef enum logic [2:0] {
      S_BOOT       = 3'd0,
      S_IDLE       = 3'd1,
      S_REPLACE    = 3'd2,
      S_REFILL     = 3'd3,
      S_INVALIDATE = 3'd4
   } icache_state_e;

   typedef struct packed {
      logic                     en;
      logic [IC_P_SETS-1:0]     set;
      logic [IC_TAG_W-1:0]      tag;
      logic                     valid;
      logic [IC_WAY_MASK_W-1:0] way;   // One bit per way, low bits only
   } tag_wr_t;

   typedef struct packed {
      logic [IC_WIN_W/8-1:0]    be;    // Zero means no write
      logic [IC_P_SETS-1:0]     set;
      logic [IC_P_BEATS-1:0]    beat;
      logic [IC_WIN_W-1:0]      data;
      logic [IC_WAY_MASK_W-1:0] way;
   } data_wr_t;

endpackage

// File: source/icache_tag_array.sv
// Tag and valid storage per way with synchronous read, stage-2 tag compare and hit encoding
`timescale 1ns/1ps

module icache_tag_array
#(
   parameter int P_WAYS = 1
)
(
   input  logic                                  clk,
   input  logic                                  arst_n_i,
   input  logic                                  rd_en_i,
   input  logic [icache_pkg::IC_P_SETS-1:0]      rd_set_i,
   input  icache_pkg::icache_addr_u              cmp_addr_i,
   input  icache_pkg::tag_wr_t                   wr_i,
   output logic [(1<<P_WAYS)-1:0]                hit_o,
   output logic [P_WAYS-1:0]                     hit_way_o
);

   import icache_pkg::*;

   localparam int WAYS = 1 << P_WAYS;

   genvar w;

   generate
      for (w = 0; w < WAYS; w = w + 1)
         begin : gen_way
            logic [IC_TAG_W:0]    mem [IC_SETS];   // {tag, valid}
            logic [IC_TAG_W-1:0]  rd_tag_q;
            logic                 rd_v_q;
            logic [IC_P_SETS-1:0] rd_set_q;
            logic                 wr_en;

            assign wr_en = wr_i.en & wr_i.way[w];

            always_ff @(posedge clk)
               begin
                  if (wr_en)
                     mem[wr_i.set] <= {wr_i.tag, wr_i.valid};
               end

            // Read port keeps its set so that later writes to it show up in stage 2
            always_ff @(posedge clk or negedge arst_n_i)
               begin
                  if (!arst_n_i)
                     begin
                        rd_tag_q <= '0;
                        rd_v_q   <= 1'b0;
                        rd_set_q <= '0;
                     end
                  else if (rd_en_i)
                     begin
                        {rd_tag_q, rd_v_q} <= mem[rd_set_i];
                        rd_set_q           <= rd_set_i;
                     end
                  else if (wr_en && (wr_i.set == rd_set_q))
                     begin
                        rd_tag_q <= wr_i.tag;   // Refill or invalidate of the held set
                        rd_v_q   <= wr_i.valid;
                     end
               end

            assign hit_o[w] = rd_v_q & (rd_tag_q == cmp_addr_i.lookup.tag);
         end
   endgenerate

   // Lowest hitting way wins
   always_comb
      begin
         hit_way_o = '0;
         for (int i = WAYS - 1; i >= 0; i--)
            begin
               if (hit_o[i])
                  hit_way_o = P_WAYS'(i);
            end
      end

endmodule

// File: source/icache_data_array.sv
// Byte-enabled payload storage per way, read one fetch window at a time by set and beat
`timescale 1ns/1ps

module icache_data_array
#(
   parameter int P_WAYS = 1
)
(
   input  logic                                         clk,
   input  logic                                         rd_en_i,
   input  icache_pkg::icache_addr_u                     rd_addr_i,
   input  icache_pkg::data_wr_t                         wr_i,
   output logic [(1<<P_WAYS)-1:0][icache_pkg::IC_WIN_W-1:0] win_o
);

   import icache_pkg::*;

   localparam int WAYS  = 1 << P_WAYS;
   localparam int IDX_W = IC_P_SETS + IC_P_BEATS;

   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;

   assign rd_idx = {rd_addr_i.lookup.set, rd_addr_i.refill.beat};
   assign wr_idx = {wr_i.set, wr_i.beat};

   genvar w;

   generate
      for (w = 0; w < WAYS; w = w + 1)
         begin : gen_way
            logic [IC_WIN_W-1:0] mem [IC_SETS*IC_BEATS];
            logic [IC_WIN_W-1:0] rd_q;
            logic [IDX_W-1:0]    rd_idx_q;
            logic                wr_en;

            assign wr_en = (|wr_i.be) & wr_i.way[w];

            always_ff @(posedge clk)
               begin
                  if (wr_en)
                     for (int b = 0; b < IC_WIN_W/8; b++)
                        if (wr_i.be[b])
                           mem[wr_idx][b*8 +: 8] <= wr_i.data[b*8 +: 8];
               end

            // A refill beat landing on the held window updates it in place
            always_ff @(posedge clk)
               begin
                  if (rd_en_i)
                     begin
                        rd_q     <= mem[rd_idx];
                        rd_idx_q <= rd_idx;
                     end
                  else if (wr_en && (wr_idx == rd_idx_q))
                     for (int b = 0; b < IC_WIN_W/8; b++)
                        if (wr_i.be[b])
                           rd_q[b*8 +: 8] <= wr_i.data[b*8 +: 8];
               end

            assign win_o[w] = rd_q;
         end
   endgenerate

endmodule

// File: source/icache_ctrl.sv
// I-cache controller with boot sweep, miss refill over AXI, invalidate and the fetch window register
`timescale 1ns/1ps

module icache_ctrl
#(
   parameter int P_WAYS = 1
)
(
   input  logic                                         clk,
   input  logic                                         arst_n_i,
   input  icache_pkg::icache_addr_u                     fetch_addr_i,
   input  logic                                         kill_i,
   input  logic                                         inv_i,
   input  icache_pkg::icache_addr_u                     inv_addr_i,
   input  logic [(1<<P_WAYS)-1:0]                       hit_i,
   input  logic [P_WAYS-1:0]                            hit_way_i,
   input  logic [(1<<P_WAYS)-1:0][icache_pkg::IC_WIN_W-1:0] win_i,
   output logic                                         rd_en_o,
   output logic [icache_pkg::IC_P_SETS-1:0]             rd_set_o,
   output icache_pkg::icache_addr_u                     rd_addr_o,
   output icache_pkg::icache_addr_u                     cmp_addr_o,
   output icache_pkg::tag_wr_t                          tag_wr_o,
   output icache_pkg::data_wr_t                         data_wr_o,
   output logic                                         stall_o,
   output logic                                         op_stall_o,
   output logic [icache_pkg::IC_WIN_W-1:0]              ins_o,
   output logic                                         valid_o,
   output logic                                         ar_valid_o,
   input  logic                                         ar_ready_i,
   output logic [icache_pkg::IC_AW-1:0]                 ar_addr_o,
   output logic [7:0]                                   ar_len_o,
   input  logic                                         r_valid_i,
   output logic                                         r_ready_o,
   input  logic [icache_pkg::AXI_DW-1:0]                r_data_i,
   input  logic                                         r_last_i
);

   import icache_pkg::*;

   localparam int WAYS = 1 << P_WAYS;

   icache_state_e          state_q;
   icache_state_e          state_nxt;
   logic                   p_ce;
   logic                   s1_valid_q;
   logic                   s2_valid_q;
   icache_addr_u           s1_addr_q;
   icache_addr_u           s2_addr_q;
   icache_addr_u           inv_addr_q;
   logic                   inv_pend_q;
   logic [IC_P_SETS-1:0]   free_idx_q;   // Boot index and clock victim pointer
   logic [P_WAYS-1:0]      victim_q;
   logic [IC_P_BEATS-1:0]  beat_q;
   logic                   miss;
   logic                   hds_r;
   logic                   hds_r_last;
   logic                   get_beat;

   assign p_ce       = ~stall_o;
   assign miss       = s1_valid_q & ~|hit_i & ~kill_i;
   assign hds_r      = r_valid_i & r_ready_o;
   assign hds_r_last = hds_r & r_last_i;
   assign get_beat   = (s2_addr_q.refill.beat == beat_q);

   always_comb
      begin
         state_nxt = state_q;
         case (state_q)
            S_BOOT:
               if (&free_idx_q)
                  state_nxt = S_IDLE;
            S_IDLE:
               if (miss)
                  state_nxt = S_REPLACE;   // A miss goes first, the invalidate waits
               else if (inv_i | inv_pend_q)
                  state_nxt = S_INVALIDATE;
            S_REPLACE:
               state_nxt = S_REFILL;
            S_REFILL:
               if (hds_r_last)
                  state_nxt = S_IDLE;
            S_INVALIDATE:
               state_nxt = S_IDLE;
            default:
               state_nxt = S_IDLE;
         endcase
      end

   always_ff @(posedge clk or negedge arst_n_i)
      begin
         if (!arst_n_i)
            begin
               state_q    <= S_BOOT;
               free_idx_q <= '0;
               s1_valid_q <= 1'b0;
               s2_valid_q <= 1'b0;
               inv_pend_q <= 1'b0;
               beat_q     <= '0;
               ar_valid_o <= 1'b0;
            end
         else
            begin
               state_q    <= state_nxt;
               free_idx_q <= free_idx_q + 1'b1;
               inv_pend_q <= (inv_pend_q | inv_i) & (state_nxt != S_INVALIDATE);
               if (p_ce)
                  begin
                     s1_valid_q <= 1'b1;
                     s2_valid_q <= s1_valid_q & ~kill_i;
                  end
               if (state_q != S_REFILL)
                  beat_q <= '0;
               else if (hds_r)
                  beat_q <= beat_q + 1'b1;
               if (state_q == S_REPLACE)
                  ar_valid_o <= 1'b1;
               else if (ar_ready_i)
                  ar_valid_o <= 1'b0;
            end
      end

   always_ff @(posedge clk)
      begin
         if (p_ce)
            begin
               s1_addr_q <= fetch_addr_i;
               s2_addr_q <= s1_addr_q;
            end
         if (inv_i)
            inv_addr_q <= inv_addr_i;
         if (state_q == S_REPLACE)
            begin
               victim_q  <= free_idx_q[P_WAYS-1:0];
               ar_addr_o <= {s2_addr_q.refill.line, {IC_P_LINE{1'b0}}};
            end
         if (state_q == S_REFILL)
            begin
               if (hds_r && get_beat)
                  ins_o <= r_data_i;   // Critical beat straight from the bus
            end
         else if (p_ce)
            ins_o <= win_i[hit_way_i];
      end

   always_comb
      begin
         case (state_q)
            S_BOOT,
            S_REPLACE:    rd_set_o = free_idx_q;
            S_INVALIDATE: rd_set_o = inv_addr_q.lookup.set;
            default:      rd_set_o = fetch_addr_i.lookup.set;
         endcase
         rd_addr_o            = fetch_addr_i;
         rd_addr_o.lookup.set = rd_set_o;
      end

   always_comb
      begin
         tag_wr_o = '0;
         case (state_q)
            S_BOOT:
               begin
                  tag_wr_o.en  = 1'b1;
                  tag_wr_o.set = free_idx_q;
                  tag_wr_o.way = IC_WAY_MASK_W'((1 << WAYS) - 1);
               end
            S_REPLACE:
               begin
                  tag_wr_o.en    = 1'b1;
                  tag_wr_o.set   = s2_addr_q.lookup.set;
                  tag_wr_o.tag   = s2_addr_q.lookup.tag;
                  tag_wr_o.valid = 1'b1;
                  tag_wr_o.way   = IC_WAY_MASK_W'(1) << free_idx_q[P_WAYS-1:0];
               end
            S_INVALIDATE:
               begin
                  tag_wr_o.en  = 1'b1;   // Whole set goes invalid
                  tag_wr_o.set = inv_addr_q.lookup.set;
                  tag_wr_o.way = IC_WAY_MASK_W'((1 << WAYS) - 1);
               end
            default: ;
         endcase
      end

   assign data_wr_o.be   = {(IC_WIN_W/8){hds_r}};
   assign data_wr_o.set  = s2_addr_q.lookup.set;
   assign data_wr_o.beat = beat_q;
   assign data_wr_o.data = r_data_i;
   assign data_wr_o.way  = IC_WAY_MASK_W'(1) << victim_q;

   assign rd_en_o    = p_ce;
   assign cmp_addr_o = s1_addr_q;
   assign stall_o    = (state_q != S_IDLE);
   assign op_stall_o = inv_i | stall_o;
   assign valid_o    = s2_valid_q & ~stall_o;
   assign ar_len_o   = 8'(IC_BEATS - 1);
   assign r_ready_o  = (state_q == S_REFILL);

endmodule

// File: source/icache_top.sv
// I-cache top level joining tag array, payload array and controller to fetch and AXI ports
`timescale 1ns/1ps

module icache_top
#(
   parameter int P_WAYS = 1
)
(
   input  logic                              clk,
   input  logic                              arst_n_i,
   // Core side
   input  logic [icache_pkg::IC_AW-1:0]      fetch_addr_i,
   input  logic                              kill_i,
   input  logic                              inv_i,
   input  logic [icache_pkg::IC_AW-1:0]      inv_addr_i,
   output logic                              stall_o,
   output logic                              op_stall_o,
   output logic [icache_pkg::IC_WIN_W-1:0]   ins_o,
   output logic                              valid_o,
   // AXI read port
   output logic                              ar_valid_o,
   input  logic                              ar_ready_i,
   output logic [icache_pkg::IC_AW-1:0]      ar_addr_o,
   output logic [7:0]                        ar_len_o,
   input  logic                              r_valid_i,
   output logic                              r_ready_o,
   input  logic [icache_pkg::AXI_DW-1:0]     r_data_i,
   input  logic                              r_last_i
);

   import icache_pkg::*;

   logic                               rd_en;
   logic [IC_P_SETS-1:0]               rd_set;
   icache_addr_u                       rd_addr;
   icache_addr_u                       cmp_addr;
   tag_wr_t                            tag_wr;
   data_wr_t                           data_wr;
   logic [(1<<P_WAYS)-1:0]             hit;
   logic [P_WAYS-1:0]                  hit_way;
   logic [(1<<P_WAYS)-1:0][IC_WIN_W-1:0] win;

   icache_tag_array #(.P_WAYS(P_WAYS)) u_tag_array (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .rd_en_i    (rd_en),
      .rd_set_i   (rd_set),
      .cmp_addr_i (cmp_addr),
      .wr_i       (tag_wr),
      .hit_o      (hit),
      .hit_way_o  (hit_way)
   );

   icache_data_array #(.P_WAYS(P_WAYS)) u_data_array (
      .clk       (clk),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .wr_i      (data_wr),
      .win_o     (win)
   );

   icache_ctrl #(.P_WAYS(P_WAYS)) u_ctrl (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .fetch_addr_i (fetch_addr_i),
      .kill_i       (kill_i),
      .inv_i        (inv_i),
      .inv_addr_i   (inv_addr_i),
      .hit_i        (hit),
      .hit_way_i    (hit_way),
      .win_i        (win),
      .rd_en_o      (rd_en),
      .rd_set_o     (rd_set),
      .rd_addr_o    (rd_addr),
      .cmp_addr_o   (cmp_addr),
      .tag_wr_o     (tag_wr),
      .data_wr_o    (data_wr),
      .stall_o      (stall_o),
      .op_stall_o   (op_stall_o),
      .ins_o        (ins_o),
      .valid_o      (valid_o),
      .ar_valid_o   (ar_valid_o),
      .ar_ready_i   (ar_ready_i),
      .ar_addr_o    (ar_addr_o),
      .ar_len_o     (ar_len_o),
      .r_valid_i    (r_valid_i),
      .r_ready_o    (r_ready_o),
      .r_data_i     (r_data_i),
      .r_last_i     (r_last_i)
   );

endmodule

// File: test/icache_assertions.sv
// Concurrent checks on the I-cache boundary, bound into icache_top by the testbench
`timescale 1ns/1ps

module icache_assertions
(
   input  logic                              clk,
   input  logic                              arst_n_i,
   input  logic [icache_pkg::IC_AW-1:0]      fetch_addr_i,
   input  logic                              kill_i,
   input  logic                              inv_i,
   input  logic                              stall_o,
   input  logic                              op_stall_o,
   input  logic [icache_pkg::IC_WIN_W-1:0]   ins_o,
   input  logic                              valid_o,
   input  logic                              ar_valid_o,
   input  logic                              ar_ready_i,
   input  logic [icache_pkg::IC_AW-1:0]      ar_addr_o,
   input  logic [7:0]                        ar_len_o,
   input  logic                              r_valid_i,
   input  logic                              r_ready_o,
   input  logic                              r_last_i
);

   import icache_pkg::*;

   int               fail_cnt = 0;
   logic [IC_AW-1:0] p1_addr;      // Fetch in the compare stage
   logic [IC_AW-1:0] p2_addr;      // Fetch owning ins_o
   logic             p1_v;
   logic             p2_v;
   logic [6:0]       boot_cnt;
   logic             ar_open;      // Burst accepted and last beat not yet seen
   logic [2:0]       r_cnt;

   // Memory rule with the aligned beat address above and its inverse below
   function automatic logic [IC_WIN_W-1:0] mem_word(input logic [IC_AW-1:0] a);
      logic [31:0] b;
      b = {a[31:3], 3'b000};
      return {b, ~b};
   endfunction

   always_ff @(posedge clk or negedge arst_n_i)
      begin
         if (!arst_n_i)
            begin
               p1_addr  <= '0;
               p2_addr  <= '0;
               p1_v     <= 1'b0;
               p2_v     <= 1'b0;
               boot_cnt <= '0;
               ar_open  <= 1'b0;
               r_cnt    <= '0;
            end
         else
            begin
               if (boot_cnt != 7'd127)
                  boot_cnt <= boot_cnt + 1'b1;
               if (!stall_o)
                  begin
                     p1_addr <= fetch_addr_i;
                     p1_v    <= 1'b1;
                     p2_addr <= p1_addr;
                     p2_v    <= p1_v & ~kill_i;   // Killed fetch never reaches the output
                  end
               if (ar_valid_o && ar_ready_i)
                  ar_open <= 1'b1;
               if (r_valid_i && r_ready_o)
                  begin
                     r_cnt <= r_last_i ? 3'd0 : r_cnt + 1'b1;
                     if (r_last_i)
                        ar_open <= 1'b0;
                  end
            end
      end

   a_boot: assert property (@(posedge clk) disable iff (!arst_n_i)
      boot_cnt < 7'd64 |-> stall_o && !valid_o && !ar_valid_o && !r_ready_o)
      else
         begin
            fail_cnt++;
            $error("Cache left boot early or started a burst during boot");
         end

   a_boot_end: assert property (@(posedge clk) disable iff (!arst_n_i)
      boot_cnt == 7'd64 |-> !stall_o)
      else
         begin
            fail_cnt++;
            $error("Boot sweep did not end after 64 cycles");
         end

   a_data: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_o |-> p2_v && ins_o == mem_word(p2_addr))
      else
         begin
            fail_cnt++;
            $error("CHECK FAILED ins_o: expected %h, got %h", mem_word(p2_addr), ins_o);
         end

   // A fetch in stage 2 comes out in every cycle the cache is not stalled
   a_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
      p2_v && !stall_o |-> valid_o)
      else
         begin
            fail_cnt++;
            $error("CHECK FAILED valid_o: expected %h, got %h", 1'b1, valid_o);
         end

   a_op_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
      op_stall_o == (inv_i || stall_o))
      else
         begin
            fail_cnt++;
            $error("CHECK FAILED op_stall_o: expected %h, got %h",
                   inv_i || stall_o, op_stall_o);
         end

   a_ar_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_o |-> ar_addr_o == {p2_addr[IC_AW-1:IC_P_LINE], {IC_P_LINE{1'b0}}}
                     && ar_len_o == 8'(IC_BEATS - 1))
      else
         begin
            fail_cnt++;
            $error("CHECK FAILED ar_addr_o: expected %h, got %h, ar_len_o %h",
                   {p2_addr[IC_AW-1:IC_P_LINE], {IC_P_LINE{1'b0}}}, ar_addr_o, ar_len_o);
         end

   a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
      else
         begin
            fail_cnt++;
            $error("AR request dropped or changed before ready");
         end

   a_one_ar: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_o |-> stall_o && !ar_open)
      else
         begin
            fail_cnt++;
            $error("Second AR issued for one miss");
         end

   a_r_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_open |-> r_ready_o)
      else
         begin
            fail_cnt++;
            $error("R ready dropped before the last beat of the burst");
         end

   a_r_len: assert property (@(posedge clk) disable iff (!arst_n_i)
      r_valid_i && r_ready_o && r_last_i |-> r_cnt == 3'(IC_BEATS - 1))
      else
         begin
            fail_cnt++;
            $error("CHECK FAILED r_cnt: got %h at last beat", r_cnt);
         end

endmodule

// File: test/icache_tb.sv
// Testbench for icache_top with a rule-based AXI memory and directed fetch sequences
`timescale 1ns/1ps

module icache_tb;

   logic        clk;
   logic        arst_n;
   logic [31:0] fetch_addr_i;
   logic        kill_i;
   logic        inv_i;
   logic [31:0] inv_addr_i;
   logic        stall_o;
   logic        op_stall_o;
   logic [63:0] ins_o;
   logic        valid_o;
   logic        ar_valid_o;
   logic        ar_ready_i;
   logic [31:0] ar_addr_o;
   logic [7:0]  ar_len_o;
   logic        r_valid_i;
   logic        r_ready_o;
   logic [63:0] r_data_i;
   logic        r_last_i;

   integer      seed;
   int          cyc;          // Rising edges since reset release
   int          ar_cnt;
   int          check_errs;
   int          timeouts;
   int          mem_beat;
   int          ar_wait;
   logic        ar_armed;
   logic        mem_busy;
   logic [31:0] mem_addr;

   localparam logic [31:0] PARK = 32'h0000_4000;
   localparam logic [31:0] A0   = 32'h0000_1058;   // Set 2 with the critical beat last
   localparam logic [31:0] A1   = 32'h0000_1840;   // Same set with another tag
   localparam logic [31:0] A2   = 32'h0000_3100;
   localparam logic [31:0] A3   = 32'h0000_7e60;

   icache_top dut0 (
      .clk (clk), .arst_n_i (arst_n),
      .fetch_addr_i (fetch_addr_i), .kill_i (kill_i), .inv_i (inv_i), .inv_addr_i (inv_addr_i),
      .stall_o (stall_o), .op_stall_o (op_stall_o), .ins_o (ins_o), .valid_o (valid_o),
      .ar_valid_o (ar_valid_o), .ar_ready_i (ar_ready_i), .ar_addr_o (ar_addr_o),
      .ar_len_o (ar_len_o), .r_valid_i (r_valid_i), .r_ready_o (r_ready_o),
      .r_data_i (r_data_i), .r_last_i (r_last_i)
   );

   bind icache_top icache_assertions u_assert (
      .clk (clk), .arst_n_i (arst_n_i), .fetch_addr_i (fetch_addr_i), .kill_i (kill_i),
      .inv_i (inv_i), .stall_o (stall_o), .op_stall_o (op_stall_o), .ins_o (ins_o),
      .valid_o (valid_o), .ar_valid_o (ar_valid_o),
      .ar_ready_i (ar_ready_i), .ar_addr_o (ar_addr_o), .ar_len_o (ar_len_o),
      .r_valid_i (r_valid_i), .r_ready_o (r_ready_o), .r_last_i (r_last_i)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
            cyc <= 0;
         else
            cyc <= cyc + 1;
      end

   function automatic logic [63:0] beat_word(input logic [31:0] a);
      logic [31:0] b;
      b = {a[31:3], 3'b000};
      return {b, ~b};
   endfunction

   // AXI memory model that accepts AR after 0 to 3 cycles and returns four beats with gaps
   always @(negedge clk)
      begin
         if (!arst_n)
            begin
               ar_ready_i = 1'b0;
               r_valid_i  = 1'b0;
               r_last_i   = 1'b0;
               mem_busy   = 1'b0;
               ar_armed   = 1'b0;
            end
         else if (!mem_busy)
            begin
               if (ar_ready_i)   // Handshake at the last rising edge
                  begin
                     ar_ready_i = 1'b0;
                     ar_armed   = 1'b0;
                     ar_cnt     = ar_cnt + 1;
                     mem_addr   = ar_addr_o;
                     mem_beat   = 0;
                     mem_busy   = 1'b1;
                  end
               else if (ar_valid_o)
                  begin
                     if (!ar_armed)
                        begin
                           ar_wait  = $random(seed) & 3;
                           ar_armed = 1'b1;
                        end
                     if (ar_wait == 0)
                        ar_ready_i = 1'b1;
                     else
                        ar_wait = ar_wait - 1;
                  end
            end
         else
            begin
               if (r_valid_i)   // r_ready_o is high for the whole burst
                  begin
                     if (r_last_i)
                        mem_busy = 1'b0;
                     mem_beat = mem_beat + 1;
                  end
               r_valid_i = 1'b0;
               r_last_i  = 1'b0;
               if (mem_busy && (($random(seed) & 3) != 0))
                  begin
                     r_valid_i = 1'b1;
                     r_data_i  = beat_word(mem_addr + 32'(mem_beat * 8));
                     r_last_i  = (mem_beat == 3);
                  end
            end
      end

   task automatic run_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_idle(input int max_cyc);
      int n;
      n = 0;
      while (stall_o && n < max_cyc)
         begin
            @(negedge clk);
            n++;
         end
      if (stall_o)
         begin
            $display("TIMEOUT: cache still stalled after %0d cycles", max_cyc);
            timeouts++;
         end
   endtask

   // Victim way follows the clock counter parity at the drive edge
   task automatic fetch_in_way(input logic [31:0] addr, input int way);
      int n;
      n = 0;
      while (((cyc & 1) != way || stall_o) && n < 8)
         begin
            @(negedge clk);
            n++;
         end
      if ((cyc & 1) != way || stall_o)
         begin
            $display("TIMEOUT: no idle cycle with the wanted victim way");
            timeouts++;
         end
      fetch_addr_i = addr;
      run_cycles(3);
      wait_idle(100);
   endtask

   task automatic fetch(input logic [31:0] addr);
      wait_idle(100);
      fetch_addr_i = addr;
      run_cycles(3);
      wait_idle(100);
   endtask

   task automatic check_ar(input int exp);
      if (ar_cnt != exp)
         begin
            $display("CHECK FAILED ar_cnt: expected %h, got %h", exp, ar_cnt);
            check_errs++;
         end
   endtask

   initial
      begin
         int total;
         seed         = 32'he218;
         ar_cnt       = 0;
         check_errs   = 0;
         timeouts     = 0;
         arst_n       = 1'b0;
         fetch_addr_i = PARK;
         kill_i       = 1'b0;
         inv_i        = 1'b0;
         inv_addr_i   = '0;
         ar_ready_i   = 1'b0;
         r_valid_i    = 1'b0;
         r_data_i     = '0;
         r_last_i     = 1'b0;
         repeat (2) @(posedge clk);
         @(negedge clk);
         arst_n = 1'b1;

         wait_idle(200);              // Boot sweep
         run_cycles(3);
         wait_idle(100);              // Parking line refill
         check_ar(1);
         fetch_in_way(A0, 0);
         check_ar(2);
         fetch_in_way(A1, 1);
         check_ar(3);
         fetch_addr_i = A0;           // Back-to-back hits over both ways
         run_cycles(1);
         fetch_addr_i = A1 + 32'h8;
         run_cycles(1);
         fetch_addr_i = A0 - 32'h18;
         run_cycles(1);
         fetch_addr_i = A1 + 32'h10;
         run_cycles(4);
         wait_idle(100);
         check_ar(3);

         fetch_addr_i = A3;           // Cold line killed in the compare stage
         run_cycles(1);
         kill_i       = 1'b1;
         fetch_addr_i = A0;
         run_cycles(1);
         kill_i = 1'b0;
         wait_idle(100);
         check_ar(3);

         fetch(A2);
         check_ar(4);
         inv_addr_i = A0;
         inv_i      = 1'b1;
         run_cycles(1);
         inv_i = 1'b0;
         run_cycles(2);
         wait_idle(20);
         fetch(A0 - 32'h10);
         check_ar(5);

         for (int i = 0; i < 8; i++)
            begin
               fetch(32'h0010_0000 + 32'(i * 32'h40) + ($random(seed) & 32'h18));
               check_ar(6 + i);
            end
         run_cycles(4);

         total = dut0.u_assert.fail_cnt + check_errs + timeouts;
         $display("Result: assertion failures %0d, check failures %0d, timeouts %0d",
                  dut0.u_assert.fail_cnt, check_errs, timeouts);
         if (total == 0)
            $display("NO ERRORS");
         else
            $display("ERRORS FOUND");
         $finish;
      end

endmodule

// File: filelist.f
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_ctrl.sv
source/icache_top.sv
test/icache_assertions.sv
test/icache_tb.sv

// File: Makefile
# Verilator flow for the I-cache testbench

TOP = icache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
